/* axi_b_xbar.f */
axi_b_xbar_pkg.sv
b_resp_fifo.sv
b_default_slave.sv
b_channel_router.sv
axi_b_xbar.sv
b_resp_checker.sv
tb_axi_b_xbar.sv

/* axi_b_xbar.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_b_xbar
    import axi_b_xbar_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n_i,
    // Slave 0
    input  b_slv_t s0_b_i,
    input  logic   s0_valid_i,
    output logic   s0_ready_o,
    // Slave 1
    input  b_slv_t s1_b_i,
    input  logic   s1_valid_i,
    output logic   s1_ready_o,
    // Slave 2
    input  b_slv_t s2_b_i,
    input  logic   s2_valid_i,
    output logic   s2_ready_o,
    // Default slave
    input  logic   err_aw_valid_i,
    input  b_slv_t err_aw_ids_i,
    output logic   err_aw_ready_o,
    input  logic   err_w_last_valid_i,
    output logic   err_w_ready_o,
    // Master 1
    output b_mst_t m1_b_o,
    output logic   m1_valid_o,
    input  logic   m1_ready_i,
    // Master 2
    output b_mst_t m2_b_o,
    output logic   m2_valid_o,
    input  logic   m2_ready_i
);

    b_slv_t [NUM_SRC-1:0] src_b;
    logic   [NUM_SRC-1:0] src_valid;
    logic   [NUM_SRC-1:0] src_ready;

    b_resp_fifo i_fifo_s0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_b_i      (s0_b_i),
        .in_valid_i  (s0_valid_i),
        .in_ready_o  (s0_ready_o),
        .out_b_o     (src_b[0]),
        .out_valid_o (src_valid[0]),
        .out_ready_i (src_ready[0])
    );

    b_resp_fifo i_fifo_s1 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_b_i      (s1_b_i),
        .in_valid_i  (s1_valid_i),
        .in_ready_o  (s1_ready_o),
        .out_b_o     (src_b[1]),
        .out_valid_o (src_valid[1]),
        .out_ready_i (src_ready[1])
    );

    b_resp_fifo i_fifo_s2 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_b_i      (s2_b_i),
        .in_valid_i  (s2_valid_i),
        .in_ready_o  (s2_ready_o),
        .out_b_o     (src_b[2]),
        .out_valid_o (src_valid[2]),
        .out_ready_i (src_ready[2])
    );

    // Lowest priority input of the router
    b_default_slave i_default_slave (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .err_aw_valid_i     (err_aw_valid_i),
        .err_aw_ids_i       (err_aw_ids_i),
        .err_aw_ready_o     (err_aw_ready_o),
        .err_w_last_valid_i (err_w_last_valid_i),
        .err_w_ready_o      (err_w_ready_o),
        .out_b_o            (src_b[3]),
        .out_valid_o        (src_valid[3]),
        .out_ready_i        (src_ready[3])
    );

    b_channel_router i_router (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .src_b_i     (src_b),
        .src_valid_i (src_valid),
        .src_ready_o (src_ready),
        .m1_b_o      (m1_b_o),
        .m1_valid_o  (m1_valid_o),
        .m1_ready_i  (m1_ready_i),
        .m2_b_o      (m2_b_o),
        .m2_valid_o  (m2_valid_o),
        .m2_ready_i  (m2_ready_i)
    );

endmodule

`default_nettype wire

/* axi_b_xbar_pkg.sv */
`default_nettype none

package axi_b_xbar_pkg;

    localparam int ID_BITS  = 4;
    localparam int MST_BITS = 2;
    localparam int IDS_BITS = MST_BITS + ID_BITS;

    // Three slaves plus the default slave
    localparam int NUM_SRC  = 4;
    localparam int SRC_BITS = $clog2(NUM_SRC);

    localparam int FIFO_DEPTH    = 4;
    localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_BITS = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [MST_BITS-1:0] {
        MST_NONE = 2'd0,
        MST_1    = 2'd1,
        MST_2    = 2'd2,
        MST_RSVD = 2'd3
    } mst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    typedef enum logic {
        RT_IDLE,
        RT_BUSY
    } rt_state_e;

    // Slave side beat with the master index on top
    typedef struct packed {
        mst_e               master;
        logic [ID_BITS-1:0] id;
        resp_e              resp;
    } b_slv_t;

    typedef struct packed {
        logic [ID_BITS-1:0] id;
        resp_e              resp;
    } b_mst_t;

endpackage

`default_nettype wire

/* b_channel_router.sv */
`timescale 1ns/10ps
`default_nettype none

module b_channel_router
    import axi_b_xbar_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  b_slv_t [NUM_SRC-1:0] src_b_i,
    input  logic   [NUM_SRC-1:0] src_valid_i,
    output logic   [NUM_SRC-1:0] src_ready_o,
    output b_mst_t               m1_b_o,
    output logic                 m1_valid_o,
    input  logic                 m1_ready_i,
    output b_mst_t               m2_b_o,
    output logic                 m2_valid_o,
    input  logic                 m2_ready_i
);

    rt_state_e           state_q;
    rt_state_e           state_d;
    logic [SRC_BITS-1:0] grant_q;
    logic [SRC_BITS-1:0] grant_d;
    b_slv_t              sel_b;
    b_mst_t              mst_b;
    logic                busy;
    logic                sel_valid;
    logic                ready_m;
    logic                xfer;

    // Fixed priority where the lowest index wins
    always_comb begin
        grant_d = grant_q;
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            if (src_valid_i[i]) begin
                grant_d = SRC_BITS'(i);
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            RT_IDLE: if (|src_valid_i) state_d = RT_BUSY;
            RT_BUSY: if (xfer) state_d = RT_IDLE;
            default: state_d = RT_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RT_IDLE;
            grant_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == RT_IDLE) begin
                grant_q <= grant_d;
            end
        end
    end

    assign busy      = (state_q == RT_BUSY);
    assign sel_b     = src_b_i[grant_q];
    assign sel_valid = busy && src_valid_i[grant_q];

    always_comb begin
        case (sel_b.master)
            MST_1:   ready_m = m1_ready_i;
            MST_2:   ready_m = m2_ready_i;
            // No master behind index 0 or 3 so the beat is sunk
            default: ready_m = 1'b1;
        endcase
    end

    assign xfer = sel_valid && ready_m;

    always_comb begin
        src_ready_o          = '0;
        src_ready_o[grant_q] = busy && ready_m;
    end

    // Master index stripped on the way out
    assign mst_b      = '{id: sel_b.id, resp: sel_b.resp};
    assign m1_b_o     = mst_b;
    assign m2_b_o     = mst_b;
    assign m1_valid_o = sel_valid && (sel_b.master == MST_1);
    assign m2_valid_o = sel_valid && (sel_b.master == MST_2);

    // Granted source must keep its beat until the handshake
    a_grant_held: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (sel_valid && !ready_m) |=> (sel_valid && $stable(grant_q) && $stable(sel_b))
    ) else $error("b_channel_router: granted beat moved while stalled");

endmodule

`default_nettype wire

/* b_default_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module b_default_slave
    import axi_b_xbar_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   err_aw_valid_i,
    input  b_slv_t err_aw_ids_i,
    output logic   err_aw_ready_o,
    input  logic   err_w_last_valid_i,
    output logic   err_w_ready_o,
    output b_slv_t out_b_o,
    output logic   out_valid_o,
    input  logic   out_ready_i
);

    logic                aw_seen_q;
    logic                w_seen_q;
    logic [IDS_BITS-1:0] aw_ids_q;
    logic                aw_xfer;
    logic                w_xfer;
    logic                out_xfer;

    assign err_aw_ready_o = !aw_seen_q;
    assign err_w_ready_o  = !w_seen_q;
    assign aw_xfer        = err_aw_valid_i && err_aw_ready_o;
    assign w_xfer         = err_w_last_valid_i && err_w_ready_o;

    // Respond only once address and last data are both in
    assign out_valid_o = aw_seen_q && w_seen_q;
    assign out_xfer    = out_valid_o && out_ready_i;

    // Extended ID with the master index above the transaction ID
    always_ff @(posedge clk) begin
        if (aw_xfer) begin
            aw_ids_q <= {err_aw_ids_i.master, err_aw_ids_i.id};
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            aw_seen_q <= 1'b0;
            w_seen_q  <= 1'b0;
        end else if (out_xfer) begin
            aw_seen_q <= 1'b0;
            w_seen_q  <= 1'b0;
        end else begin
            if (aw_xfer) aw_seen_q <= 1'b1;
            if (w_xfer)  w_seen_q  <= 1'b1;
        end
    end

    assign out_b_o = '{master: mst_e'(aw_ids_q[IDS_BITS-1:ID_BITS]),
                       id:     aw_ids_q[ID_BITS-1:0],
                       resp:   DECERR};

    a_hold_beat: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_b_o))
    ) else $error("b_default_slave: beat changed while stalled");

endmodule

`default_nettype wire

/* b_resp_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module b_resp_checker
    import axi_b_xbar_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  b_slv_t [2:0] s_b_i,
    input  logic   [2:0] s_valid_i,
    input  logic   [2:0] s_ready_i,
    input  logic         err_aw_valid_i,
    input  b_slv_t       err_aw_ids_i,
    input  logic         err_aw_ready_i,
    input  logic         err_w_last_valid_i,
    input  logic         err_w_ready_i,
    input  b_mst_t       m1_b_i,
    input  logic         m1_valid_i,
    input  logic         m1_ready_i,
    input  b_mst_t       m2_b_i,
    input  logic         m2_valid_i,
    input  logic         m2_ready_i,
    output int           err_cnt_o,
    output int           pending_o
);

    // Expected beats in one queue per source and master
    b_mst_t exp_q [NUM_SRC*2][$];
    b_slv_t aw_ids   = '0;
    logic   aw_seen  = 1'b0;
    logic   w_seen   = 1'b0;
    logic   rst_prev = 1'b0;
    int     err_cnt  = 0;
    int     pending  = 0;

    assign err_cnt_o = err_cnt;
    assign pending_o = pending;

    function automatic logic [2:0] qidx(input logic [1:0] src, input logic dest);
        return {src, dest};
    endfunction

    // Master 1 maps to queue 0 and master 2 to queue 1 while other codes are sunk
    function automatic int expect_beat(input b_slv_t b, output b_mst_t beat);
        beat.id   = b.id;
        beat.resp = b.resp;
        case (b.master)
            MST_1:   return 0;
            MST_2:   return 1;
            default: return -1;
        endcase
    endfunction

    task automatic push_expected(input logic [1:0] src, input b_slv_t b);
        b_mst_t beat;
        int     dest;
        dest = expect_beat(b, beat);
        if (dest >= 0) begin
            exp_q[qidx(src, dest[0])].push_back(beat);
            pending++;
        end
    endtask

    task automatic check_idle(input string name, input logic valid);
        if (valid) begin
            $display("error %0t ns %s expected 0 got 1", $time, name);
            err_cnt++;
        end
    endtask

    task automatic match_master(input logic dest, input string name, input b_mst_t got);
        logic [2:0] q;
        int         hit;
        int         first;
        hit   = -1;
        first = -1;
        // Any source may be next while each source keeps its own order
        for (int s = 0; s < NUM_SRC; s++) begin
            q = qidx(2'(s), dest);
            if (exp_q[q].size() != 0) begin
                if (first < 0) first = s;
                if (hit < 0 && exp_q[q][0] == got) hit = s;
            end
        end
        if (hit >= 0) begin
            void'(exp_q[qidx(2'(hit), dest)].pop_front());
            pending--;
        end else if (first < 0) begin
            $display("unexpected beat on %s at %0t ns with id=%h resp=%0d",
                     name, $time, got.id, got.resp);
            err_cnt++;
        end else begin
            q = qidx(2'(first), dest);
            $display("error %0t ns %s expected id=%h resp=%0d got id=%h resp=%0d",
                     $time, name, exp_q[q][0].id, exp_q[q][0].resp, got.id, got.resp);
            err_cnt++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n_i || !rst_prev) begin
            check_idle("m1_valid_o", m1_valid_i);
            check_idle("m2_valid_o", m2_valid_i);
        end
        if (rst_n_i) begin
            if (s_valid_i[0] && s_ready_i[0]) push_expected(2'd0, s_b_i[0]);
            if (s_valid_i[1] && s_ready_i[1]) push_expected(2'd1, s_b_i[1]);
            if (s_valid_i[2] && s_ready_i[2]) push_expected(2'd2, s_b_i[2]);
            // Default slave answers once address and last data are both in
            if (err_aw_valid_i && err_aw_ready_i) begin
                aw_ids  = err_aw_ids_i;
                aw_seen = 1'b1;
            end
            if (err_w_last_valid_i && err_w_ready_i) w_seen = 1'b1;
            if (aw_seen && w_seen) begin
                aw_ids.resp = DECERR;
                push_expected(2'd3, aw_ids);
                aw_seen = 1'b0;
                w_seen  = 1'b0;
            end
            if (m1_valid_i && m1_ready_i) match_master(1'b0, "m1_b_o", m1_b_i);
            if (m2_valid_i && m2_ready_i) match_master(1'b1, "m2_b_o", m2_b_i);
        end
        rst_prev = rst_n_i;
    end

endmodule

`default_nettype wire

/* b_resp_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module b_resp_fifo
    import axi_b_xbar_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n_i,
    input  b_slv_t in_b_i,
    input  logic   in_valid_i,
    output logic   in_ready_o,
    output b_slv_t out_b_o,
    output logic   out_valid_o,
    input  logic   out_ready_i
);

    b_slv_t                   mem_q [FIFO_DEPTH];
    logic [FIFO_PTR_BITS-1:0] wr_ptr_q;
    logic [FIFO_PTR_BITS-1:0] rd_ptr_q;
    logic [FIFO_CNT_BITS-1:0] count_q;
    logic                     full;
    logic                     push;
    logic                     pop;

    assign full        = (count_q == FIFO_CNT_BITS'(FIFO_DEPTH));
    assign out_valid_o = (count_q != '0);
    assign out_b_o     = mem_q[rd_ptr_q];
    assign pop         = out_valid_o && out_ready_i;

    // Full FIFO still takes a beat when the head leaves
    assign in_ready_o = !full || pop;
    assign push       = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_b_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == FIFO_PTR_BITS'(FIFO_DEPTH - 1)) ? '0
                                                                      : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == FIFO_PTR_BITS'(FIFO_DEPTH - 1)) ? '0
                                                                      : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // A full FIFO that accepts while draining stays full
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (push && full) |=> full
    ) else $error("b_resp_fifo: full FIFO changed level on push and pop");

    a_count_range: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        count_q <= FIFO_CNT_BITS'(FIFO_DEPTH)
    ) else $error("b_resp_fifo: occupancy out of range");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the B channel crossbar testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_axi_b_xbar -f axi_b_xbar.f -o sim_axi_b_xbar \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_axi_b_xbar > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

/* tb_axi_b_xbar.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_axi_b_xbar;
    import axi_b_xbar_pkg::*;

    localparam int WAIT_LIMIT  = 1000;
    localparam int DRAIN_LIMIT = 500;

    logic         clk = 1'b0;
    logic         rst_n_i;
    b_slv_t [2:0] s_b;
    logic   [2:0] s_valid;
    logic   [2:0] s_ready;
    logic         err_aw_valid;
    b_slv_t       err_aw_ids;
    logic         err_aw_ready;
    logic         err_w_last_valid;
    logic         err_w_ready;
    b_mst_t       m1_b;
    logic         m1_valid;
    logic         m1_ready = 1'b0;
    b_mst_t       m2_b;
    logic         m2_valid;
    logic         m2_ready = 1'b0;
    integer       seed = 32'hba21b6d9;
    int           check_errs;
    int           pending;
    int           timeouts = 0;
    int           tb_errs = 0;
    logic         stall = 1'b0;
    logic         aborted = 1'b0;
    logic         full_seen = 1'b0;

    always #50 clk = ~clk;

    axi_b_xbar i_axi_b_xbar (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .s0_b_i             (s_b[0]),
        .s0_valid_i         (s_valid[0]),
        .s0_ready_o         (s_ready[0]),
        .s1_b_i             (s_b[1]),
        .s1_valid_i         (s_valid[1]),
        .s1_ready_o         (s_ready[1]),
        .s2_b_i             (s_b[2]),
        .s2_valid_i         (s_valid[2]),
        .s2_ready_o         (s_ready[2]),
        .err_aw_valid_i     (err_aw_valid),
        .err_aw_ids_i       (err_aw_ids),
        .err_aw_ready_o     (err_aw_ready),
        .err_w_last_valid_i (err_w_last_valid),
        .err_w_ready_o      (err_w_ready),
        .m1_b_o             (m1_b),
        .m1_valid_o         (m1_valid),
        .m1_ready_i         (m1_ready),
        .m2_b_o             (m2_b),
        .m2_valid_o         (m2_valid),
        .m2_ready_i         (m2_ready)
    );

    b_resp_checker i_checker (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .s_b_i              (s_b),
        .s_valid_i          (s_valid),
        .s_ready_i          (s_ready),
        .err_aw_valid_i     (err_aw_valid),
        .err_aw_ids_i       (err_aw_ids),
        .err_aw_ready_i     (err_aw_ready),
        .err_w_last_valid_i (err_w_last_valid),
        .err_w_ready_i      (err_w_ready),
        .m1_b_i             (m1_b),
        .m1_valid_i         (m1_valid),
        .m1_ready_i         (m1_ready),
        .m2_b_i             (m2_b),
        .m2_valid_i         (m2_valid),
        .m2_ready_i         (m2_ready),
        .err_cnt_o          (check_errs),
        .pending_o          (pending)
    );

    // Both masters held off during a stall so the FIFOs fill up
    always @(negedge clk) begin
        logic [31:0] r;
        r = $random(seed);
        m1_ready = !stall && (r[0] || r[1]);
        m2_ready = !stall && (r[1] || r[2]);
    end

    always @(posedge clk) begin
        if (|(s_valid & ~s_ready)) full_seen = 1'b1;
    end

    function automatic b_slv_t random_beat(input logic [1:0] src);
        logic [31:0] r;
        b_slv_t      b;
        r        = $random(seed);
        b.master = r[7] ? mst_e'(r[1:0]) : (r[0] ? MST_2 : MST_1);
        // Low ID bits name the source so queue heads stay apart
        b.id     = {r[3:2], src};
        b.resp   = resp_e'(r[5:4]);
        return b;
    endfunction

    task automatic wait_accept(input int which, input string what);
        int   waited;
        logic ok;
        waited = 0;
        ok     = 1'b0;
        while (!ok && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
            case (which)
                0:       ok = s_ready[0];
                1:       ok = s_ready[1];
                2:       ok = s_ready[2];
                3:       ok = err_aw_ready;
                default: ok = err_w_ready;
            endcase
        end
        if (!ok) begin
            $display("timeout: %s was never accepted", what);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    task automatic drive_slave(input logic [1:0] idx, input int beats, input int max_gap);
        int gap;
        for (int k = 0; k < beats && !aborted; k++) begin
            gap = {$random(seed)} % (max_gap + 1);
            @(negedge clk);
            if (gap != 0) begin
                s_valid[idx] = 1'b0;
                repeat (gap) @(negedge clk);
            end
            s_b[idx]     = random_beat(idx);
            s_valid[idx] = 1'b1;
            wait_accept(int'(idx), "slave beat");
        end
        @(negedge clk);
        s_valid[idx] = 1'b0;
    endtask

    task automatic pulse_err(input logic is_aw, input b_slv_t ids);
        @(negedge clk);
        if (is_aw) begin
            err_aw_ids   = ids;
            err_aw_valid = 1'b1;
            wait_accept(3, "error AW");
        end else begin
            err_w_last_valid = 1'b1;
            wait_accept(4, "error W last");
        end
        @(negedge clk);
        err_aw_valid     = 1'b0;
        err_w_last_valid = 1'b0;
    endtask

    task automatic drive_default_slave(input int count);
        b_slv_t      ids;
        logic [31:0] r;
        for (int k = 0; k < count && !aborted; k++) begin
            ids = random_beat(2'd3);
            r   = $random(seed);
            repeat (r[2:1]) @(negedge clk);
            // Either half of the unmapped write may come first
            pulse_err(!r[0], ids);
            pulse_err(r[0], ids);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("timeout: %0d expected beats never reached a master", pending);
            timeouts++;
        end
    endtask

    task automatic finish_run();
        $display("errors: checks=%0d tb=%0d timeouts=%0d", check_errs, tb_errs, timeouts);
        if (check_errs == 0 && tb_errs == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin
        rst_n_i          = 1'b0;
        s_b              = '0;
        s_valid          = '0;
        err_aw_valid     = 1'b0;
        err_aw_ids       = '0;
        err_w_last_valid = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        stall   = 1'b1;
        fork
            drive_slave(2'd0, 8, 0);
            drive_slave(2'd1, 8, 0);
            drive_slave(2'd2, 8, 0);
            begin
                repeat (20) @(negedge clk);
                stall = 1'b0;
            end
        join
        fork
            drive_slave(2'd0, 30, 3);
            drive_slave(2'd1, 30, 3);
            drive_slave(2'd2, 30, 3);
            drive_default_slave(10);
        join
        wait_drain();
        // Idle cycles to catch late duplicates
        repeat (10) @(posedge clk);
        if (!full_seen) begin
            $display("no slave FIFO ever filled, back-pressure was not exercised");
            tb_errs++;
        end
        finish_run();
    end

endmodule

`default_nettype wire
